/* keypad_lab.f */
source/keypad_pkg.sv
source/timing_pkg.sv
source/keypad_scanner.sv
source/key_decoder.sv
source/keypad_debouncer.sv
source/keypad_top.sv
bench/tb_clock.sv
bench/keypad_model.sv
bench/keypad_tb.sv

/* Makefile */
TOP = keypad_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f keypad_lab.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* bench/keypad_tb.sv */
`timescale 1ns/1ps

module keypad_tb
    import keypad_pkg::*;
    import timing_pkg::*;
();

    // =========================================================================
    // Cycle budgets
    // =========================================================================
    localparam int CLK_PERIOD = 20;
    localparam int LAT_BOUND  = 3*SCAN_DWELL + SYNC_STAGES + DEBOUNCE_MAX + 2;
    localparam int HOLD_EXTRA = 20;              // Hold past the pulse
    localparam int SETTLE     = 2*SCAN_DWELL;    // Release back to idle scan
    localparam int N_BOUNCE   = 10;
    localparam int BOUNCE_MAX = 64;              // Longest bounce phase from 6 LFSR bits
    localparam int GLITCH_LEN = 150;             // Well under DEBOUNCE_MAX
    localparam int PRESS_BUDGET = LAT_BOUND + HOLD_EXTRA + SETTLE;
    localparam int TOTAL_CYCLES = (4*SCAN_DWELL + 2)
                                + NUM_KEYS * PRESS_BUDGET
                                + N_BOUNCE * BOUNCE_MAX + PRESS_BUDGET
                                + LAT_BOUND + 3*DEBOUNCE_MAX + SETTLE + PRESS_BUDGET
                                + GLITCH_LEN + LAT_BOUND + SETTLE
                                + 3*LAT_BOUND + 2*SETTLE;

    logic                clk;
    logic                rst_n;
    logic [NUM_ROWS-1:0] row;
    logic [NUM_COLS-1:0] col;
    logic [NUM_KEYS-1:0] press_mask;
    logic                key_valid;
    key_code_t           key_code;
    debounce_state_t     db_state;               // Only for messages

    int          mismatches  = 0;
    int          failures    = 0;
    int          pulse_count = 0;
    key_code_t   last_code   = KEY_NONE;
    logic [15:0] lfsr        = 16'd14930;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    keypad_model u_model (.row(row), .press_mask(press_mask), .col(col));

    keypad_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .col       (col),
        .row       (row),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    assign db_state = dut0.u_debouncer.state;

    // Pulse monitor samples the values of the cycle that just ended
    always @(posedge clk) begin
        if (rst_n && key_valid) begin
            pulse_count <= pulse_count + 1;
            last_code   <= key_code;
        end
    end

    // =========================================================================
    // Helpers
    // =========================================================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic get_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);              // One step per bit
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic logic [NUM_KEYS-1:0] key_bit(input int r, input int c);
        return NUM_KEYS'(1) << (r*NUM_COLS + c);
    endfunction

    function automatic int expected_code(input int r, input int c);
        return r*NUM_COLS + c + 1;
    endfunction

    function automatic logic [NUM_ROWS-1:0] row_pattern(input int idx);
        logic [NUM_ROWS-1:0] pat;
        pat      = '1;                           // Idle rows sit high
        pat[idx] = 1'b0;                         // Scanned row pulled low
        return pat;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_pulse(input int base, input int limit);
        int n;
        n = 0;
        while (pulse_count == base && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (pulse_count == base) begin
            $display("No key_valid pulse within %0d cycles of the press, debouncer in %s",
                     limit, db_state.name());
            failures++;
        end
    endtask

    // Press alone and expect one pulse with the right code before release
    task automatic press_and_release(input int r, input int c);
        int base;
        base       = pulse_count;
        press_mask = key_bit(r, c);
        wait_pulse(base, LAT_BOUND);
        check_value("key_code", last_code, expected_code(r, c));
        idle_cycles(HOLD_EXTRA);
        press_mask = '0;
        idle_cycles(SETTLE);
        check_value("pulse_count", pulse_count - base, 1);
    endtask

    task automatic print_summary();
        $display("Summary: %0d mismatches, %0d other failures, %0d key_valid pulses",
                 mismatches, failures, pulse_count);
    endtask

    // =========================================================================
    // Directed tests
    // =========================================================================
    task automatic reset_state();
        int         idx;
        logic [2:0] seen;
        check_value("row", row, row_pattern(0));
        check_value("key_valid", key_valid, 0);
        check_value("key_code", key_code, KEY_NONE);
        idx  = 0;
        seen = '0;
        repeat (4*SCAN_DWELL) begin
            @(negedge clk);
            if (row !== row_pattern(idx)) begin
                idx = (idx + 1) % NUM_ROWS;      // Next row in scan order
                check_value("row", row, row_pattern(idx));
            end
            seen = seen | ~row;
        end
        check_value("rows_seen", seen, 3'b111);
    endtask

    task automatic clean_presses();
        for (int r = 0; r < NUM_ROWS; r++)
            for (int c = 0; c < NUM_COLS; c++)
                press_and_release(r, c);
    endtask

    task automatic bounce_press(input int r, input int c);
        int base;
        int len;
        base = pulse_count;
        for (int i = 0; i < N_BOUNCE; i++) begin
            get_bits(6, len);
            press_mask = press_mask ^ key_bit(r, c);  // Contact chatter
            idle_cycles(len + 1);
        end
        check_value("pulse_count", pulse_count - base, 0);
        press_and_release(r, c);
    endtask

    task automatic hold_freeze(input int r, input int c);
        int                  base;
        int                  moves;
        logic [NUM_ROWS-1:0] held_row;
        base       = pulse_count;
        press_mask = key_bit(r, c);
        wait_pulse(base, LAT_BOUND);
        check_value("key_code", last_code, expected_code(r, c));
        held_row = row;
        moves    = 0;
        repeat (3*DEBOUNCE_MAX) begin
            @(negedge clk);
            if (row !== held_row)
                moves++;
        end
        check_value("row_moves", moves, 0);
        check_value("row", held_row, row_pattern(r));   // Parked on the key's row
        check_value("pulse_count", pulse_count - base, 1);
        press_mask = '0;
        idle_cycles(SETTLE);
        press_and_release(r, c);                 // New press is read again
        check_value("pulse_count", pulse_count - base, 2);
    endtask

    task automatic short_glitch(input int r, input int c);
        int base;
        base       = pulse_count;
        press_mask = key_bit(r, c);
        idle_cycles(GLITCH_LEN);
        press_mask = '0;
        idle_cycles(LAT_BOUND + SETTLE);
        check_value("pulse_count", pulse_count - base, 0);
    endtask

    task automatic multi_key();
        int base;
        base       = pulse_count;
        press_mask = key_bit(1, 0) | key_bit(1, 3);   // Two columns in the same row
        idle_cycles(LAT_BOUND);
        check_value("pulse_count", pulse_count - base, 0);
        press_mask = '0;
        idle_cycles(SETTLE);
        press_mask = key_bit(0, 1);
        wait_pulse(base, LAT_BOUND);
        check_value("key_code", last_code, expected_code(0, 1));
        press_mask = press_mask | key_bit(2, 2);     // Second key while held
        idle_cycles(LAT_BOUND);
        check_value("pulse_count", pulse_count - base, 1);
        press_mask = '0;
        idle_cycles(SETTLE);
    endtask

    // =========================================================================
    // Main sequence and watchdog
    // =========================================================================
    initial begin
        press_mask = '0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        reset_state();
        clean_presses();
        bounce_press(2, 1);
        hold_freeze(1, 2);
        short_glitch(0, 3);
        multi_key();
        print_summary();
        if (mismatches == 0 && failures == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Run timed out after %0d cycles", 2 * TOTAL_CYCLES);
        failures++;
        print_summary();
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* bench/keypad_model.sv */
`timescale 1ns/1ps

module keypad_model
    import keypad_pkg::*;
(
    input  logic [NUM_ROWS-1:0] row,          // Driven by the DUT, active low
    input  logic [NUM_KEYS-1:0] press_mask,   // Bit r*4+c closes switch (r, c)
    output logic [NUM_COLS-1:0] col           // Back to the DUT, active low
);

    // =========================================================================
    // Switch matrix
    // =========================================================================
    // A closed switch ties its column to its row, so a low row pulls
    // the column low and everything else floats up to the pull-ups
    always_comb begin
        col = '1;                                // Pull-ups
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                if (!row[r] && press_mask[r*NUM_COLS + c])
                    col[c] = 1'b0;               // Closed switch on the active row
            end
        end
    end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                  // 20 ns period
    end

    // Reset held over three rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* source/keypad_top.sv */
`timescale 1ns/1ps

module keypad_top
    import keypad_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_COLS-1:0] col,          // From the keypad, active low
    output logic [NUM_ROWS-1:0] row,          // To the keypad, active low
    output logic                key_valid,
    output key_code_t           key_code
);

    // =========================================================================
    // Internal nets
    // =========================================================================
    logic [1:0]          row_idx;
    logic [NUM_COLS-1:0] col_sync;
    logic                key_detected;
    logic                scan_stop;               // Debouncer back to scanner
    key_code_t           raw_code;

    keypad_scanner u_scanner (
        .clk          (clk),
        .rst_n        (rst_n),
        .col          (col),
        .scan_stop    (scan_stop),
        .row          (row),
        .row_idx      (row_idx),
        .col_sync     (col_sync),
        .key_detected (key_detected)
    );

    key_decoder u_decoder (
        .row_idx  (row_idx),
        .col_sync (col_sync),
        .raw_code (raw_code)
    );

    keypad_debouncer u_debouncer (
        .clk          (clk),
        .rst_n        (rst_n),
        .raw_code     (raw_code),
        .key_detected (key_detected),
        .col_sync     (col_sync),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .scan_stop    (scan_stop)
    );

endmodule

/* source/keypad_debouncer.sv */
`timescale 1ns/1ps

module keypad_debouncer
    import keypad_pkg::*;
    import timing_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  key_code_t           raw_code,     // From the decoder
    input  logic                key_detected, // From the scanner
    input  logic [NUM_COLS-1:0] col_sync,
    output logic                key_valid,    // One cycle per accepted press
    output key_code_t           key_code,
    output logic                scan_stop
);

    debounce_state_t     state, state_next;
    logic [DB_CNT_W-1:0] db_cnt;
    logic [DB_CNT_W-1:0] db_cnt_next;
    key_code_t           key_q;                  // Code captured at press start
    logic [NUM_COLS-1:0] col_prev;               // Last cycle's columns
    logic                press_start;
    logic                released;
    logic                at_max;

    // =========================================================================
    // Press and release qualification
    // =========================================================================
    // Columns still moving means bounce or a second key, so no start
    assign press_start = key_detected && (raw_code != KEY_NONE) && (col_sync == col_prev);
    assign released    = !key_detected || (raw_code == KEY_NONE);
    assign at_max      = (db_cnt == DB_CNT_W'(DEBOUNCE_MAX));

    always_comb begin
        state_next  = state;
        db_cnt_next = db_cnt;
        case (state)
            DB_IDLE: begin
                db_cnt_next = '0;
                if (press_start)
                    state_next = DB_DEBOUNCING;
            end
            DB_DEBOUNCING: begin
                if (at_max)                      // Pulse cycle always lands in KEY_HELD
                    state_next = DB_KEY_HELD;
                else if (released)
                    state_next = DB_IDLE;
                else
                    db_cnt_next = db_cnt + 1'b1;
            end
            DB_KEY_HELD: begin
                if (released)
                    state_next = DB_IDLE;        // Ready for the next press
            end
            default: state_next = DB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= DB_IDLE;
            db_cnt   <= '0;
            col_prev <= '0;
        end else begin
            state    <= state_next;
            db_cnt   <= db_cnt_next;
            col_prev <= col_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (state == DB_IDLE && press_start)
            key_q <= raw_code;                   // Latch on entry to debounce
    end

    // =========================================================================
    // Outputs
    // =========================================================================
    assign key_valid = (state == DB_DEBOUNCING) && at_max;
    assign key_code  = key_valid ? key_q : KEY_NONE;
    assign scan_stop = (state != DB_IDLE);       // Scanner parks on the pressed row

    a_valid_then_held: assert property (
        @(posedge clk) disable iff (!rst_n) key_valid |=> state == DB_KEY_HELD
    );
    a_valid_single: assert property (
        @(posedge clk) disable iff (!rst_n) key_valid |=> !key_valid
    );
    a_valid_has_code: assert property (
        @(posedge clk) disable iff (!rst_n) key_valid |-> key_code != KEY_NONE
    );

endmodule

/* source/key_decoder.sv */
`timescale 1ns/1ps

module key_decoder
    import keypad_pkg::*;
(
    input  logic [1:0]          row_idx,
    input  logic [NUM_COLS-1:0] col_sync,     // Active high column hits
    output key_code_t           raw_code
);

    // =========================================================================
    // Column encoder
    // =========================================================================
    logic [1:0] col_idx;
    logic       one_col;                         // Exactly one column active

    always_comb begin
        col_idx = 2'd0;
        one_col = 1'b1;
        case (col_sync)
            4'b0001: col_idx = 2'd0;
            4'b0010: col_idx = 2'd1;
            4'b0100: col_idx = 2'd2;
            4'b1000: col_idx = 2'd3;
            default: one_col = 1'b0;             // None, or several keys in a row
        endcase
    end

    // =========================================================================
    // Code formation
    // =========================================================================
    // One spare bit so an out of range row never wraps into a legal code
    logic [4:0] code_val;

    always_comb begin
        code_val = 5'(row_idx) * 5'(NUM_COLS) + 5'(col_idx) + 5'd1;
        if (one_col && (code_val <= 5'(NUM_KEYS)))
            raw_code = key_code_t'(code_val[3:0]);
        else
            raw_code = KEY_NONE;
    end

endmodule

/* source/keypad_scanner.sv */
`timescale 1ns/1ps

module keypad_scanner
    import keypad_pkg::*;
    import timing_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_COLS-1:0] col,          // Raw column lines, active low
    input  logic                scan_stop,    // Freeze on the current row
    output logic [NUM_ROWS-1:0] row,          // One row pulled low at a time
    output logic [1:0]          row_idx,
    output logic [NUM_COLS-1:0] col_sync,     // Synchronized, active high
    output logic                key_detected
);

    // =========================================================================
    // Column synchronizer
    // =========================================================================
    logic [SYNC_STAGES-1:0][NUM_COLS-1:0] sync_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;                        // All columns idle
        end else begin
            sync_q[0] <= ~col;                   // Invert so a pressed key reads 1
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign col_sync = sync_q[SYNC_STAGES-1];

    // =========================================================================
    // Row dwell and advance
    // =========================================================================
    logic [DWELL_W-1:0] dwell_cnt;
    logic               dwell_end;
    logic               settled;

    assign dwell_end = (dwell_cnt == DWELL_W'(SCAN_DWELL - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
            row_idx   <= 2'd0;
        end else if (!scan_stop) begin          // Hold everything while a key is busy
            if (dwell_end) begin
                dwell_cnt <= '0;
                if (row_idx == 2'(NUM_ROWS - 1))
                    row_idx <= 2'd0;             // Wrap back to the top row
                else
                    row_idx <= row_idx + 2'd1;
            end else begin
                dwell_cnt <= dwell_cnt + 1'b1;
            end
        end
    end

    assign row = ~(NUM_ROWS'(1) << row_idx);     // Active low, one-hot

    // Synchronizer still carries the previous row early in the dwell
    assign settled      = (dwell_cnt >= DWELL_W'(SYNC_STAGES));
    assign key_detected = settled && (|col_sync);

    // Exactly one row driven low at all times
    a_row_one_low: assert property (
        @(posedge clk) disable iff (!rst_n) $countones(~row) == 1
    );

endmodule

/* source/timing_pkg.sv */
// Scan and debounce timing, all in clock cycles
package timing_pkg;

    // =========================================================================
    // Row scan
    // =========================================================================
    localparam int SCAN_DWELL  = 8;              // Cycles each row stays driven
    localparam int DWELL_W     = 3;              // Holds 0 .. SCAN_DWELL-1
    localparam int SYNC_STAGES = 2;              // Flops on the column inputs

    // =========================================================================
    // Debounce
    // =========================================================================
    // Shortened debounce window, real hardware would use about 20 ms
    localparam int DEBOUNCE_MAX = 255;           // Terminal count of the debouncer
    localparam int DB_CNT_W     = 8;             // Wide enough for DEBOUNCE_MAX

endpackage

/* source/keypad_pkg.sv */
// Keypad geometry and the shared key and debouncer encodings
package keypad_pkg;

    // =========================================================================
    // Matrix geometry
    // =========================================================================
    localparam int NUM_ROWS = 3;                 // Rows driven by the scanner
    localparam int NUM_COLS = 4;                 // Column lines read back
    localparam int NUM_KEYS = NUM_ROWS * NUM_COLS;

    // Key code = row * NUM_COLS + col + 1, zero means no key
    typedef enum logic [3:0] {
        KEY_NONE = 4'd0,
        KEY_R0C0 = 4'd1,
        KEY_R0C1 = 4'd2,
        KEY_R0C2 = 4'd3,
        KEY_R0C3 = 4'd4,
        KEY_R1C0 = 4'd5,
        KEY_R1C1 = 4'd6,
        KEY_R1C2 = 4'd7,
        KEY_R1C3 = 4'd8,
        KEY_R2C0 = 4'd9,
        KEY_R2C1 = 4'd10,
        KEY_R2C2 = 4'd11,
        KEY_R2C3 = 4'd12
    } key_code_t;

    typedef enum logic [1:0] {
        DB_IDLE,                                 // Scanning, nothing pressed
        DB_DEBOUNCING,                           // Press seen, counting stable cycles
        DB_KEY_HELD                              // Accepted, waiting for release
    } debounce_state_t;

endpackage
